// ==== sources.f ====
verilog/lau_pkg.sv
verilog/prefix_and_or_cendaround.sv
verilog/add_mod_2np1.sv
verilog/mul_mod_2np1.sv
verilog/mod_arith_unit.sv
test/mod_arith_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with the FAST and the SLOW prefix network
set -e
cd "$(dirname "$0")"

for speed in FAST SLOW; do
	if [ "$speed" = "FAST" ]; then use_fast=1; else use_fast=0; fi
	echo "=== speed $speed ==="
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module mod_arith_unit_tb -Guse_fast=$use_fast \
		-Mdir "obj_dir_$speed" -f sources.f
	out=$("./obj_dir_$speed/Vmod_arith_unit_tb") || { printf '%s\n' "$out"; exit 1; }
	printf '%s\n' "$out"
	if ! printf '%s\n' "$out" | grep -qx "Everything OK"; then
		echo "speed $speed: pass message not found"
		exit 1
	fi
done

echo "both speed settings passed"

// ==== test/mod_arith_unit_tb.sv ====
`default_nettype none

module mod_arith_unit_tb import lau_pkg::*; #(
	// 1 selects the Kogge-Stone prefix tree, 0 the serial chain
	parameter int use_fast = 1
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int     width       = 16;
	localparam speed_e speed       = (use_fast != 0) ? FAST : SLOW;
	// 65537 for width 16
	localparam longint modulus     = (longint'(1) << width) + 1;
	localparam int     num_table   = 20;
	localparam int     num_random  = 40;
	localparam int     num_busy    = 2;
	// cycles from the start sample to done
	localparam int     add_latency = 2;
	localparam int     mul_latency = width + 4;
	// 24 cycles cover the longest operation with margin
	localparam int     timeout_limit = (num_table + num_random + num_busy) * 24 + 100;

	typedef logic [width-1:0] word_t;

	typedef struct packed {
		op_e   op_sel;
		word_t x;
		word_t y;
		word_t expected;
	} entry_t;

	logic  clk;
	logic  reset;
	logic  start;
	op_e   op;
	word_t a;
	word_t b;
	word_t result;
	logic  done;
	logic  busy;

	entry_t      table_entries [num_table];
	int          done_count;
	int          cycle_count;
	logic [15:0] lfsr_state;

	mod_arith_unit #(
		.width (width),
		.speed (speed)
	) mod_arith_unit_i (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.op     (op),
		.a      (a),
		.b      (b),
		.result (result),
		.done   (done),
		.busy   (busy)
	);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// watchdog over the whole run
	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count > timeout_limit) begin
				$display("timeout: the run did not finish within %0d cycles", timeout_limit);
				report_failure();
			end
		end
	end

	task automatic report_failure();
		$display("Something failed");
		$fatal(1, "stopping at the first error");
	endtask

	// one clock, then 1 ns later for driving and sampling
	task automatic step_cycle();
		@(posedge clk);
		#1;
		if (done) begin
			done_count++;
		end
	endtask

	// 16-bit Galois LFSR, taps of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] galois_step(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hb400;
		end else begin
			return s >> 1;
		end
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = galois_step(lfsr_state);
		end
		return value;
	endfunction

	// true sum congruent to zero has no diminished-one code
	function automatic bit sum_is_zero(input word_t x, input word_t y);
		return ((longint'(x) + longint'(y) + 2) % modulus) == 0;
	endfunction

	// back to true values, operate modulo 2^n+1, back to diminished-one
	function automatic word_t model_result(input op_e sel, input word_t x, input word_t y);
		longint tx;
		longint ty;
		longint t;
		tx = longint'(x) + 1;
		ty = longint'(y) + 1;
		if (sel == OP_ADD) begin
			t = (tx + ty) % modulus;
		end else begin
			t = (tx * ty) % modulus;
		end
		return word_t'(t - 1);
	endfunction

	// expected values worked out by hand from the modulo rules
	task automatic load_table();
		// add, wrap past 2^n and carry-free cases
		table_entries[0]  = '{OP_ADD, 16'hffff, 16'hffff, 16'hfffe};
		table_entries[1]  = '{OP_ADD, 16'h0000, 16'h0000, 16'h0001};
		table_entries[2]  = '{OP_ADD, 16'h1234, 16'h0101, 16'h1336};
		table_entries[3]  = '{OP_ADD, 16'h8000, 16'h7ffe, 16'hffff};
		table_entries[4]  = '{OP_ADD, 16'h8000, 16'h8000, 16'h0000};
		table_entries[5]  = '{OP_ADD, 16'hffff, 16'h0005, 16'h0004};
		table_entries[6]  = '{OP_ADD, 16'h00ff, 16'h0f00, 16'h1000};
		table_entries[7]  = '{OP_ADD, 16'habcd, 16'h6543, 16'h1110};
		// mul, 2^16 * 2^16 is true 1
		table_entries[8]  = '{OP_MUL, 16'hffff, 16'hffff, 16'h0000};
		// operand 0 is true 1
		table_entries[9]  = '{OP_MUL, 16'h0000, 16'h1234, 16'h1234};
		table_entries[10] = '{OP_MUL, 16'h1234, 16'h0000, 16'h1234};
		table_entries[11] = '{OP_MUL, 16'h0001, 16'h0001, 16'h0003};
		table_entries[12] = '{OP_MUL, 16'hffff, 16'h0000, 16'hffff};
		table_entries[13] = '{OP_MUL, 16'hffff, 16'h0001, 16'hfffe};
		// 256 * 256, lo below hi
		table_entries[14] = '{OP_MUL, 16'h00ff, 16'h00ff, 16'hffff};
		table_entries[15] = '{OP_MUL, 16'h0100, 16'h0100, 16'h01ff};
		table_entries[16] = '{OP_MUL, 16'h7fff, 16'h0001, 16'hffff};
		table_entries[17] = '{OP_MUL, 16'h0002, 16'h0004, 16'h000e};
		table_entries[18] = '{OP_MUL, 16'h1000, 16'h1000, 16'h1f00};
		// (-2) * (-2), lo far below hi
		table_entries[19] = '{OP_MUL, 16'hfffe, 16'hfffe, 16'h0003};
	endtask

	// nothing may happen while the unit is idle
	task automatic check_quiet(input word_t held);
		assert (!done) else begin
			$display("ERROR done: got 0x%h, expected 0x0", done);
			report_failure();
		end
		assert (!busy) else begin
			$display("ERROR busy: got 0x%h, expected 0x0", busy);
			report_failure();
		end
		assert (result == held) else begin
			$display("ERROR result: got 0x%h, expected 0x%h", result, held);
			report_failure();
		end
	endtask

	// one operation, optionally with a second start while busy
	task automatic run_op(input op_e sel, input word_t x, input word_t y,
			input word_t expected, input int intrude_at);
		int lat;
		int exp_lat;
		int count_before;
		exp_lat = (sel == OP_ADD) ? add_latency : mul_latency;
		assert (!busy) else begin
			$display("the unit was still busy when a new operation was due");
			report_failure();
		end
		// a done still high at the start edge shows up as an extra pulse
		count_before = done_count;
		op = sel;
		a = x;
		b = y;
		start = 1'b1;
		// this edge takes the operands
		step_cycle();
		start = 1'b0;
		assert (busy) else begin
			$display("ERROR busy: got 0x%h, expected 0x1", busy);
			report_failure();
		end
		// the cycle of the start sample counts as the first
		lat = 1;
		do begin
			if (lat == intrude_at) begin
				// must be ignored, the unit is busy
				start = 1'b1;
				op = (sel == OP_ADD) ? OP_MUL : OP_ADD;
				a = ~x;
				b = ~y;
			end
			step_cycle();
			start = 1'b0;
			lat++;
			if (!done) begin
				assert (busy) else begin
					$display("ERROR busy: got 0x%h, expected 0x1", busy);
					report_failure();
				end
			end
		end while (!done && lat < exp_lat + 4);
		assert (done) else begin
			$display("no done within %0d cycles after start", lat);
			report_failure();
		end
		assert (lat == exp_lat) else begin
			$display("done came %0d cycles after start instead of %0d", lat, exp_lat);
			report_failure();
		end
		assert (result == expected) else begin
			$display("ERROR result: got 0x%h, expected 0x%h (%s a 0x%h b 0x%h)",
				result, expected, sel.name(), x, y);
			report_failure();
		end
		assert (done_count == count_before + 1) else begin
			$display("%0d done pulses for one operation", done_count - count_before);
			report_failure();
		end
	endtask

	initial begin
		entry_t e;
		op_e    r_op;
		word_t  r_a;
		word_t  r_b;
		reset = 1'b1;
		start = 1'b0;
		op = OP_ADD;
		a = '0;
		b = '0;
		done_count = 0;
		lfsr_state = 16'd13805;
		load_table();
		repeat (8) step_cycle();
		reset = 1'b0;
		// quiet after reset
		repeat (10) begin
			step_cycle();
			check_quiet('0);
		end
		for (int i = 0; i < num_table; i++) begin
			e = table_entries[i];
			run_op(e.op_sel, e.x, e.y, e.expected, -1);
		end
		for (int i = 0; i < num_random; i++) begin
			r_op = op_e'(take_bits(1));
			r_a = word_t'(take_bits(width));
			r_b = word_t'(take_bits(width));
			if (r_op == OP_ADD && sum_is_zero(r_a, r_b)) begin
				continue;
			end
			run_op(r_op, r_a, r_b, model_result(r_op, r_a, r_b), -1);
		end
		// start while busy, mid-multiply and right after an add sample
		run_op(OP_MUL, 16'h0100, 16'h0100, 16'h01ff, 6);
		repeat (24) begin
			step_cycle();
			check_quiet(16'h01ff);
		end
		run_op(OP_ADD, 16'h1234, 16'h0101, 16'h1336, 1);
		repeat (24) begin
			step_cycle();
			check_quiet(16'h1336);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/mod_arith_unit.sv ====
`default_nettype none

module mod_arith_unit import lau_pkg::*; #(
	parameter int     width = default_width,
	parameter speed_e speed = FAST
) (
	input  logic             clk,
	input  logic             reset,
	// one-cycle strobe, ignored while busy
	input  logic             start,
	input  op_e              op,
	// operands in diminished-one form
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	// held from done until the next done
	output logic [width-1:0] result,
	output logic             done,
	output logic             busy
);

	logic             accept;
	op_e              op_q;
	logic [width-1:0] a_q;
	logic [width-1:0] b_q;
	logic [width-1:0] sum;
	logic [width-1:0] mul_product;
	logic             mul_start;
	logic             mul_valid;
	logic             finish;

	// new request only when idle
	assign accept = start && !busy;

	// multiplier starts together with the operand latch
	// it reads a_q and b_q from the next cycle on
	assign mul_start = accept && (op == OP_MUL);

	// add needs a single cycle, mul waits for the multiplier
	assign finish = busy && ((op_q == OP_ADD) || mul_valid);

	// operand registers
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q <= op;
			a_q  <= a;
			b_q  <= b;
		end
	end

	add_mod_2np1 #(
		.width (width),
		.speed (speed)
	) add_i (
		.a (a_q),
		.b (b_q),
		.s (sum)
	);

	mul_mod_2np1 #(
		.width (width)
	) mul_i (
		.clk     (clk),
		.reset   (reset),
		.start   (mul_start),
		.a       (a_q),
		.b       (b_q),
		.product (mul_product),
		.valid   (mul_valid)
	);

	// result register, busy level and done pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			done   <= 1'b0;
			busy   <= 1'b0;
		end else begin
			done <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
			end else if (finish) begin
				busy   <= 1'b0;
				done   <= 1'b1;
				result <= (op_q == OP_ADD) ? sum : mul_product;
			end
		end
	end

	// done always falls in the cycle after busy drops
	assert property (@(posedge clk) disable iff (reset) !(done && busy))
		else $error("mod_arith_unit: done and busy high together");

endmodule

`default_nettype wire

// ==== verilog/mul_mod_2np1.sv ====
`default_nettype none

module mul_mod_2np1 import lau_pkg::*; #(
	parameter int width = default_width
) (
	input  logic             clk,
	input  logic             reset,
	// one-cycle request, only accepted in IDLE
	input  logic             start,
	// diminished-one operands, held stable by the caller until valid
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	// diminished-one product modulo 2^n+1
	output logic [width-1:0] product,
	output logic             valid
);

	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		REDUCE
	} state_e;

	state_e state;
	cnt_t   cnt;

	// true values 1..2^n need one extra bit
	logic [width:0]   a_true;
	logic [width:0]   b_true;
	// full product up to 2^(2n)
	logic [2*width:0] acc;
	logic [2*width:0] acc_nxt;
	// halves of the product, 2^n is -1 modulo 2^n+1
	logic [width-1:0] lo;
	logic [width:0]   hi;
	// candidate results of the reduction
	logic [width+1:0] diff_gt;
	logic [width+1:0] diff_le;

	// the counter must reach width
	if (width > 16) begin : gen_width_check
		$error("mul_mod_2np1: width %0d does not fit the bit counter", width);
	end

	// back from diminished-one to true values
	assign a_true = {1'b0, a} + (width+1)'(1);
	assign b_true = {1'b0, b} + (width+1)'(1);

	// msb-first shift and add, one bit of b_true per cycle
	assign acc_nxt = {acc[2*width-1:0], 1'b0} +
		(b_true[cnt] ? {{width{1'b0}}, a_true} : '0);

	assign lo = acc[width-1:0];
	assign hi = acc[2*width:width];

	// lo - hi is the true product, minus one more for diminished-one
	assign diff_gt = {2'b00, lo} - {1'b0, hi} - (width+2)'(1);
	// lo <= hi wraps, so add the modulus back
	assign diff_le = diff_gt + (width+2)'(2**width + 1);

	// control
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			// ready for a start in the first cycle after reset
			cnt   <= cnt_t'(width);
			valid <= 1'b0;
		end else begin
			valid <= 1'b0;
			case (state)
				IDLE: begin
					// preload so the first step uses the msb of b_true
					cnt <= cnt_t'(width);
					if (start) begin
						state <= SHIFT;
					end
				end
				SHIFT: begin
					cnt <= cnt - cnt_t'(1);
					// width+1 steps in total, last one at cnt 0
					if (cnt == '0) begin
						state <= REDUCE;
					end
				end
				REDUCE: begin
					state <= IDLE;
					valid <= 1'b1;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				acc <= '0;
			end
			SHIFT: begin
				acc <= acc_nxt;
			end
			REDUCE: begin
				// lo == hi would mean a zero product, impossible for a prime modulus
				product <= ({1'b0, lo} > hi) ? diff_gt[width-1:0] : diff_le[width-1:0];
			end
			default: begin
				acc <= acc;
			end
		endcase
	end

	// the caller keeps start away while a product is in flight
	assert property (@(posedge clk) disable iff (reset) start |-> state == IDLE)
		else $error("mul_mod_2np1: start outside IDLE");

	// one pulse per product
	assert property (@(posedge clk) disable iff (reset) valid |=> !valid)
		else $error("mul_mod_2np1: valid longer than one cycle");

endmodule

`default_nettype wire

// ==== verilog/add_mod_2np1.sv ====
`default_nettype none

module add_mod_2np1 import lau_pkg::*; #(
	parameter int     width = default_width,
	parameter speed_e speed = FAST
) (
	// operands in diminished-one form
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	// diminished-one sum modulo 2^n+1
	output logic [width-1:0] s
);

	logic [width-1:0] gi;
	logic [width-1:0] pi;
	logic [width-1:0] pt;
	logic [width-1:0] go;
	logic             ci;
	logic             co;

	// or-propagate is enough for carries
	assign gi = a & b;
	assign pi = a | b;
	// xor-propagate for the sum bits
	assign pt = ~gi & pi;

	// group propagate is not needed for the sum
	prefix_and_or_cendaround #(
		.width (width),
		.speed (speed)
	) prefix_i (
		.gi (gi),
		.pi (pi),
		.ci (ci),
		.go (go),
		.po (),
		.co (co)
	);

	// diminished-one rule
	// add one back only when the plain sum did not overflow 2^n
	assign ci = ~co;

	// carry into bit i+1 is go[i], bit 0 takes the end-around carry
	assign s = pt ^ {go[width-2:0], ci};

endmodule

`default_nettype wire

// ==== verilog/prefix_and_or_cendaround.sv ====
`default_nettype none

module prefix_and_or_cendaround import lau_pkg::*; #(
	parameter int     width = default_width,
	parameter speed_e speed = FAST
) (
	// bit generate and propagate in
	input  logic [width-1:0] gi,
	input  logic [width-1:0] pi,
	// end-around carry in
	input  logic             ci,
	// group generate and propagate out, ci already absorbed in go
	output logic [width-1:0] go,
	output logic [width-1:0] po,
	// carry out of the whole word
	output logic             co
);

	// group generate/propagate of every prefix i..0
	// computed without ci so co can feed back as ci
	logic [width-1:0] g_pre;
	logic [width-1:0] p_pre;

	// a single bit has no prefix to compute
	if (width < 2) begin : gen_width_check
		$error("prefix_and_or_cendaround: width %0d is below 2", width);
	end

	if (speed == SLOW) begin : gen_serial

		// ripple chain
		// one and-or operator per bit, width-1 levels deep
		always_comb begin
			g_pre[0] = gi[0];
			p_pre[0] = pi[0];
			for (int i = 1; i < width; i++) begin
				g_pre[i] = gi[i] | (pi[i] & g_pre[i-1]);
				p_pre[i] = pi[i] & p_pre[i-1];
			end
		end

	end else begin : gen_tree

		// number of tree levels
		localparam int levels = $clog2(width);

		// current and next level of the tree
		logic [width-1:0] g_lvl;
		logic [width-1:0] p_lvl;
		logic [width-1:0] g_nxt;
		logic [width-1:0] p_nxt;

		// Kogge-Stone
		// level l combines each node with the node 2^l positions below
		always_comb begin
			g_lvl = gi;
			p_lvl = pi;
			for (int l = 0; l < levels; l++) begin
				g_nxt = g_lvl;
				p_nxt = p_lvl;
				// nodes below the span just pass through
				for (int i = (1 << l); i < width; i++) begin
					g_nxt[i] = g_lvl[i] | (p_lvl[i] & g_lvl[i - (1 << l)]);
					p_nxt[i] = p_lvl[i] & p_lvl[i - (1 << l)];
				end
				g_lvl = g_nxt;
				p_lvl = p_nxt;
			end
			// after the last level every node spans down to bit 0
			g_pre = g_lvl;
			p_pre = p_lvl;
		end

	end

	// generate of the full word
	// taken before ci enters, so there is no combinational loop
	assign co = g_pre[width-1];

	// late insertion of the end-around carry
	// a prefix that propagates all the way passes ci on
	assign go = g_pre | (p_pre & {width{ci}});
	assign po = p_pre;

endmodule

`default_nettype wire

// ==== verilog/lau_pkg.sv ====
`default_nettype none

package lau_pkg;

	// structure of the carry prefix network
	// SLOW selects a serial chain with width-1 operator levels
	// FAST selects a Kogge-Stone tree with log2(width) levels
	typedef enum logic {
		SLOW,
		FAST
	} speed_e;

	// operation requested at the top level
	typedef enum logic {
		OP_ADD,
		OP_MUL
	} op_e;

	// operand width of the top level unless overridden
	// 16 gives the IDEA modulus 65537
	localparam int default_width = 16;

	// bit counter of the shift-add multiplier
	// counts width down to 0, so 5 bits cover widths up to 16
	typedef logic [4:0] cnt_t;

endpackage

`default_nettype wire
